//--- ex_pkg.sv
package ex_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;

    typedef logic [WORD_W-1:0]     word_t;      // One register word
    typedef logic [2*WORD_W-1:0]   dword_t;     // Full product or the HI/LO pair
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;  // Destination register index
    typedef logic [5:0]            count_t;     // Leading bit count, 0 up to 32

    typedef enum logic [4:0] {
        OP_NOP,
        OP_OR,
        OP_AND,
        OP_NOR,
        OP_XOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_CLZ,
        OP_CLO,
        OP_MUL,
        OP_MULT,
        OP_MULTU,
        OP_MFHI,
        OP_MFLO,
        OP_MTHI,
        OP_MTLO
    } alu_op_t;

    typedef enum logic [2:0] {
        CAT_NONE,
        CAT_LOGIC,
        CAT_SHIFT,
        CAT_ARITH,
        CAT_MULT,
        CAT_MOVE
    } alu_cat_t;

    // The category is implied by the operator, so decode never has to send it
    function automatic alu_cat_t op_category(alu_op_t op);
        alu_cat_t cat;
        case (op)
            OP_OR, OP_AND, OP_NOR, OP_XOR:               cat = CAT_LOGIC;
            OP_SLL, OP_SRL, OP_SRA:                      cat = CAT_SHIFT;
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
            OP_SLT, OP_SLTU, OP_CLZ, OP_CLO:             cat = CAT_ARITH;
            OP_MUL, OP_MULT, OP_MULTU:                   cat = CAT_MULT;
            OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO:          cat = CAT_MOVE;
            default:                                     cat = CAT_NONE;
        endcase
        return cat;
    endfunction

endpackage

//--- ex_op_if.sv
interface ex_op_if;

    ex_pkg::alu_op_t op;        // Decoded operator
    ex_pkg::word_t   operand1;  // First source, also the shift amount
    ex_pkg::word_t   operand2;  // Second source or placed immediate
    logic            valid;     // Operation present this cycle

    modport source (
        output op,
        output operand1,
        output operand2,
        output valid
    );

    modport sink (
        input op,
        input operand1,
        input operand2,
        input valid
    );

endinterface

//--- ex_logic_shift.sv
module ex_logic_shift (
    ex_op_if.sink          op_bus,
    output ex_pkg::word_t  logic_shift_result
);

    logic [ex_pkg::SHAMT_W-1:0] shamt;
    ex_pkg::word_t              sra_value;

    assign shamt = op_bus.operand1[ex_pkg::SHAMT_W-1:0];  // Amount comes from operand1, not operand2

    // Arithmetic shift keeps operand2's sign in the vacated upper bits
    assign sra_value = ex_pkg::word_t'($signed(op_bus.operand2) >>> shamt);

    always_comb begin
        case (op_bus.op)
            ex_pkg::OP_OR: begin
                logic_shift_result = op_bus.operand1 | op_bus.operand2;
            end
            ex_pkg::OP_AND: begin
                logic_shift_result = op_bus.operand1 & op_bus.operand2;
            end
            ex_pkg::OP_NOR: begin
                logic_shift_result = ~(op_bus.operand1 | op_bus.operand2);
            end
            ex_pkg::OP_XOR: begin
                logic_shift_result = op_bus.operand1 ^ op_bus.operand2;
            end
            ex_pkg::OP_SLL: begin
                logic_shift_result = op_bus.operand2 << shamt;
            end
            ex_pkg::OP_SRL: begin
                logic_shift_result = op_bus.operand2 >> shamt;  // Zero fill from the top
            end
            ex_pkg::OP_SRA: begin
                logic_shift_result = sra_value;
            end
            default: begin
                logic_shift_result = '0;  // Not a logic or shift operator
            end
        endcase
    end

endmodule

//--- ex_arith.sv
module ex_arith (
    ex_op_if.sink          op_bus,
    output ex_pkg::word_t  arith_result,
    output logic           overflow
);

    ex_pkg::word_t  operand2_mux;
    ex_pkg::word_t  sum;
    ex_pkg::count_t clz_count;
    ex_pkg::count_t clo_count;
    logic           is_sub;
    logic           slt_bit;
    logic           sltu_bit;

    // Count of zeros above the highest set bit, 32 when no bit is set
    function automatic ex_pkg::count_t leading_zeros(ex_pkg::word_t w);
        ex_pkg::count_t n;
        logic           found;
        n = ex_pkg::count_t'(ex_pkg::WORD_W);
        found = 1'b0;
        for (int i = ex_pkg::WORD_W - 1; i >= 0; i--) begin
            if (w[i] && !found) begin
                n = ex_pkg::count_t'(ex_pkg::WORD_W - 1 - i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    assign is_sub = (op_bus.op == ex_pkg::OP_SUB) || (op_bus.op == ex_pkg::OP_SUBU)
        || (op_bus.op == ex_pkg::OP_SLT);

    assign operand2_mux = is_sub ? (~op_bus.operand2 + 1'b1) : op_bus.operand2;
    assign sum = op_bus.operand1 + operand2_mux;  // Shared by add, subtract and signed compare

    // Operands of equal sign giving a sum of the other sign
    assign overflow = ((op_bus.op == ex_pkg::OP_ADD) || (op_bus.op == ex_pkg::OP_SUB))
        && (op_bus.operand1[ex_pkg::WORD_W-1] == operand2_mux[ex_pkg::WORD_W-1])
        && (sum[ex_pkg::WORD_W-1] != op_bus.operand1[ex_pkg::WORD_W-1]);

    assign slt_bit = (op_bus.operand1[ex_pkg::WORD_W-1] && !op_bus.operand2[ex_pkg::WORD_W-1])
        || ((op_bus.operand1[ex_pkg::WORD_W-1] == op_bus.operand2[ex_pkg::WORD_W-1])
            && sum[ex_pkg::WORD_W-1]);  // Same signs cannot overflow, so the sum sign decides
    assign sltu_bit = op_bus.operand1 < op_bus.operand2;

    assign clz_count = leading_zeros(op_bus.operand1);
    assign clo_count = leading_zeros(~op_bus.operand1);  // Leading ones are leading zeros inverted

    always_comb begin
        case (op_bus.op)
            ex_pkg::OP_ADD, ex_pkg::OP_ADDU, ex_pkg::OP_SUB, ex_pkg::OP_SUBU: begin
                arith_result = sum;
            end
            ex_pkg::OP_SLT: begin
                arith_result = {{(ex_pkg::WORD_W-1){1'b0}}, slt_bit};
            end
            ex_pkg::OP_SLTU: begin
                arith_result = {{(ex_pkg::WORD_W-1){1'b0}}, sltu_bit};
            end
            ex_pkg::OP_CLZ: begin
                arith_result = ex_pkg::word_t'(clz_count);
            end
            ex_pkg::OP_CLO: begin
                arith_result = ex_pkg::word_t'(clo_count);
            end
            default: begin
                arith_result = '0;
            end
        endcase
    end

endmodule

//--- ex_mult.sv
module ex_mult (
    ex_op_if.sink           op_bus,
    output ex_pkg::dword_t  product
);

    logic           is_signed;
    logic           negate;
    ex_pkg::word_t  mag1;
    ex_pkg::word_t  mag2;
    ex_pkg::dword_t mag_product;

    assign is_signed = (op_bus.op == ex_pkg::OP_MUL) || (op_bus.op == ex_pkg::OP_MULT);

    // Signed operands are multiplied as magnitudes and the sign is put back afterwards
    assign mag1 = (is_signed && op_bus.operand1[ex_pkg::WORD_W-1])
        ? (~op_bus.operand1 + 1'b1) : op_bus.operand1;
    assign mag2 = (is_signed && op_bus.operand2[ex_pkg::WORD_W-1])
        ? (~op_bus.operand2 + 1'b1) : op_bus.operand2;

    assign mag_product = ex_pkg::dword_t'(mag1) * ex_pkg::dword_t'(mag2);

    assign negate = is_signed
        && (op_bus.operand1[ex_pkg::WORD_W-1] ^ op_bus.operand2[ex_pkg::WORD_W-1]);

    always_comb begin
        case (op_bus.op)
            ex_pkg::OP_MUL, ex_pkg::OP_MULT, ex_pkg::OP_MULTU: begin
                product = negate ? (~mag_product + 1'b1) : mag_product;
            end
            default: begin
                product = '0;  // Idle for every other operator
            end
        endcase
    end

endmodule

//--- ex_hilo.sv
module ex_hilo (
    input  logic            clk,
    input  logic            reset,
    ex_op_if.sink           op_bus,
    input  ex_pkg::dword_t  product,
    output ex_pkg::word_t   move_result
);

    ex_pkg::word_t hi;
    ex_pkg::word_t lo;
    ex_pkg::word_t hi_next;
    ex_pkg::word_t lo_next;
    logic          is_move;

    // Each half keeps its value unless this operation writes it
    always_comb begin
        hi_next = hi;
        lo_next = lo;
        if (op_bus.valid) begin
            case (op_bus.op)
                ex_pkg::OP_MTHI: begin
                    hi_next = op_bus.operand1;  // LO stays as it is
                end
                ex_pkg::OP_MTLO: begin
                    lo_next = op_bus.operand1;
                end
                ex_pkg::OP_MULT, ex_pkg::OP_MULTU: begin
                    hi_next = product[2*ex_pkg::WORD_W-1:ex_pkg::WORD_W];
                    lo_next = product[ex_pkg::WORD_W-1:0];
                end
                default: begin
                end
            endcase
        end
    end

    // Updated at the issue edge, so the next operation already reads the new pair
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else begin
            hi <= hi_next;
            lo <= lo_next;
        end
    end

    assign is_move = ex_pkg::op_category(op_bus.op) == ex_pkg::CAT_MOVE;

    always_comb begin
        move_result = '0;
        if (is_move) begin
            case (op_bus.op)
                ex_pkg::OP_MFHI: begin
                    move_result = hi;
                end
                ex_pkg::OP_MFLO: begin
                    move_result = lo;
                end
                default: begin
                    move_result = '0;  // MTHI and MTLO return nothing
                end
            endcase
        end
    end

endmodule

//--- ex_result_stage.sv
module ex_result_stage (
    input  logic               clk,
    input  logic               reset,
    ex_op_if.sink              op_bus,
    input  ex_pkg::reg_addr_t  dest_addr,
    input  logic               dest_write,
    input  ex_pkg::word_t      logic_shift_result,
    input  ex_pkg::word_t      arith_result,
    input  logic               overflow,
    input  ex_pkg::dword_t     product,
    input  ex_pkg::word_t      move_result,
    output logic               out_valid,
    output ex_pkg::reg_addr_t  write_addr,
    output logic               write_enable,
    output ex_pkg::word_t      write_data
);

    ex_pkg::alu_cat_t category;
    ex_pkg::word_t    data_next;
    logic             enable_next;

    assign category = ex_pkg::op_category(op_bus.op);

    always_comb begin
        case (category)
            ex_pkg::CAT_LOGIC, ex_pkg::CAT_SHIFT: begin
                data_next = logic_shift_result;  // One unit serves both categories
            end
            ex_pkg::CAT_ARITH: begin
                data_next = arith_result;
            end
            ex_pkg::CAT_MULT: begin
                data_next = product[ex_pkg::WORD_W-1:0];  // MUL keeps the low word
            end
            ex_pkg::CAT_MOVE: begin
                data_next = move_result;
            end
            default: begin
                data_next = '0;
            end
        endcase
    end

    // A signed add or subtract that overflows must not reach the register file
    assign enable_next = op_bus.valid && dest_write && !overflow;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid    <= 1'b0;
            write_enable <= 1'b0;
            write_addr   <= '0;
            write_data   <= '0;
        end else begin
            out_valid    <= op_bus.valid;
            write_enable <= enable_next;
            write_addr   <= dest_addr;
            write_data   <= data_next;
        end
    end

endmodule

//--- ex_top.sv
module ex_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               in_valid,
    input  ex_pkg::alu_op_t    operator,
    input  ex_pkg::word_t      operand1,
    input  ex_pkg::word_t      operand2,
    input  ex_pkg::reg_addr_t  dest_addr,
    input  logic               dest_write,
    output logic               out_valid,
    output ex_pkg::reg_addr_t  write_addr,
    output logic               write_enable,
    output ex_pkg::word_t      write_data
);

    ex_pkg::word_t  logic_shift_result;
    ex_pkg::word_t  arith_result;
    logic           overflow;
    ex_pkg::dword_t product;
    ex_pkg::word_t  move_result;

    ex_op_if op_bus ();

    // The decoded operation fans out to every unit over one bus
    assign op_bus.op       = operator;
    assign op_bus.operand1 = operand1;
    assign op_bus.operand2 = operand2;
    assign op_bus.valid    = in_valid;

    ex_logic_shift ex_logic_shift_inst (
        .op_bus             (op_bus),
        .logic_shift_result (logic_shift_result)
    );

    ex_arith ex_arith_inst (
        .op_bus       (op_bus),
        .arith_result (arith_result),
        .overflow     (overflow)
    );

    ex_mult ex_mult_inst (
        .op_bus  (op_bus),
        .product (product)
    );

    ex_hilo ex_hilo_inst (
        .clk         (clk),
        .reset       (reset),
        .op_bus      (op_bus),
        .product     (product),      // MULT and MULTU load the full product
        .move_result (move_result)
    );

    ex_result_stage ex_result_stage_inst (
        .clk                (clk),
        .reset              (reset),
        .op_bus             (op_bus),
        .dest_addr          (dest_addr),
        .dest_write         (dest_write),
        .logic_shift_result (logic_shift_result),
        .arith_result       (arith_result),
        .overflow           (overflow),
        .product            (product),
        .move_result        (move_result),
        .out_valid          (out_valid),
        .write_addr         (write_addr),
        .write_enable       (write_enable),
        .write_data         (write_data)
    );

endmodule

//--- tb_ex_top.sv
module tb_ex_top;

    localparam int MAX_ROWS     = 64;
    localparam int NUM_RANDOM   = 12;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;

    logic              clk;
    logic              reset;
    logic              in_valid;
    ex_pkg::alu_op_t   operator;
    ex_pkg::word_t     operand1;
    ex_pkg::word_t     operand2;
    ex_pkg::reg_addr_t dest_addr;
    logic              dest_write;
    logic              out_valid;
    ex_pkg::reg_addr_t write_addr;
    logic              write_enable;
    ex_pkg::word_t     write_data;

    logic              row_valid [MAX_ROWS];  // Low for an idle cycle
    ex_pkg::alu_op_t   row_op [MAX_ROWS];
    ex_pkg::word_t     row_operand1 [MAX_ROWS];
    ex_pkg::word_t     row_operand2 [MAX_ROWS];
    ex_pkg::reg_addr_t row_addr [MAX_ROWS];
    logic              row_write [MAX_ROWS];
    ex_pkg::word_t     row_exp_data [MAX_ROWS];
    logic              row_exp_enable [MAX_ROWS];

    int     row_count   = 0;
    int     errors      = 0;
    int     checks      = 0;
    integer seed        = 32'h7f84;
    logic   table_ready = 1'b0;  // Lets the watchdog size its limit from the table

    ex_top ex_top_inst (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .operator     (operator),
        .operand1     (operand1),
        .operand2     (operand2),
        .dest_addr    (dest_addr),
        .dest_write   (dest_write),
        .out_valid    (out_valid),
        .write_addr   (write_addr),
        .write_enable (write_enable),
        .write_data   (write_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED time %0t signal %s expected %h actual %h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic add_row(input ex_pkg::alu_op_t op, input ex_pkg::word_t a,
                           input ex_pkg::word_t b, input ex_pkg::reg_addr_t addr,
                           input logic wr, input ex_pkg::word_t data, input logic en);
        row_valid[row_count]      = 1'b1;
        row_op[row_count]         = op;
        row_operand1[row_count]   = a;
        row_operand2[row_count]   = b;
        row_addr[row_count]       = addr;
        row_write[row_count]      = wr;
        row_exp_data[row_count]   = data;
        row_exp_enable[row_count] = en;
        row_count++;
    endtask

    task automatic add_idle_row(input ex_pkg::reg_addr_t addr);
        add_row(ex_pkg::OP_NOP, '0, '0, addr, 1'b1, '0, 1'b0);
        row_valid[row_count - 1] = 1'b0;  // Write request is set but must stay unused
    endtask

    // Expected value of a random row, straight from the operator definitions
    function automatic ex_pkg::word_t reference_result(input ex_pkg::alu_op_t op,
                                                       input ex_pkg::word_t a,
                                                       input ex_pkg::word_t b);
        case (op)
            ex_pkg::OP_OR:  return a | b;
            ex_pkg::OP_AND: return a & b;
            ex_pkg::OP_NOR: return ~(a | b);
            ex_pkg::OP_XOR: return a ^ b;
            default:        return a + b;  // ADDU wraps and never suppresses the write
        endcase
    endfunction

    task automatic build_fixed_rows();
        // Logic and shift, shift amount from operand1 bits 4..0
        add_row(ex_pkg::OP_OR,    32'h0f0f00ff, 32'h00f0f0f0, 5'd1,  1'b1, 32'h0ffff0ff, 1'b1);
        add_row(ex_pkg::OP_AND,   32'hff00ff00, 32'h0ff00ff0, 5'd2,  1'b1, 32'h0f000f00, 1'b1);
        add_row(ex_pkg::OP_NOR,   32'h12345678, 32'h0000ffff, 5'd3,  1'b1, 32'hedcb0000, 1'b1);
        add_row(ex_pkg::OP_XOR,   32'haaaa5555, 32'hffff0000, 5'd4,  1'b1, 32'h55555555, 1'b1);
        add_row(ex_pkg::OP_SLL,   32'h00000024, 32'h0000000f, 5'd5,  1'b1, 32'h000000f0, 1'b1);
        add_row(ex_pkg::OP_SRL,   32'h00000008, 32'h80000000, 5'd6,  1'b1, 32'h00800000, 1'b1);
        add_row(ex_pkg::OP_SRA,   32'h00000000, 32'h80000010, 5'd7,  1'b1, 32'h80000010, 1'b1);
        add_row(ex_pkg::OP_SRA,   32'h0000001f, 32'h80000000, 5'd8,  1'b1, 32'hffffffff, 1'b1);
        add_idle_row(5'd9);
        // Arithmetic, signed overflow drops the write
        add_row(ex_pkg::OP_ADD,   32'h7fffffff, 32'h00000001, 5'd10, 1'b1, 32'h80000000, 1'b0);
        add_row(ex_pkg::OP_ADDU,  32'h7fffffff, 32'h00000001, 5'd11, 1'b1, 32'h80000000, 1'b1);
        add_row(ex_pkg::OP_SUB,   32'h80000000, 32'h00000001, 5'd12, 1'b1, 32'h7fffffff, 1'b0);
        add_row(ex_pkg::OP_SUBU,  32'h00000005, 32'h00000007, 5'd13, 1'b1, 32'hfffffffe, 1'b1);
        add_row(ex_pkg::OP_SLT,   32'hffffffff, 32'h00000001, 5'd14, 1'b1, 32'h00000001, 1'b1);
        add_row(ex_pkg::OP_SLTU,  32'hffffffff, 32'h00000001, 5'd15, 1'b1, 32'h00000000, 1'b1);
        add_row(ex_pkg::OP_CLZ,   32'h00000000, 32'h00000000, 5'd16, 1'b1, 32'h00000020, 1'b1);
        add_row(ex_pkg::OP_CLO,   32'hf0000000, 32'h00000000, 5'd17, 1'b1, 32'h00000004, 1'b1);
        // Multiply, then HI/LO read back on the very next cycle
        add_row(ex_pkg::OP_MUL,   32'hfffffffd, 32'h00000005, 5'd18, 1'b1, 32'hfffffff1, 1'b1);
        add_row(ex_pkg::OP_MULT,  32'hfffffffd, 32'h00000005, 5'd19, 1'b0, 32'hfffffff1, 1'b0);
        add_row(ex_pkg::OP_MFHI,  32'h00000000, 32'h00000000, 5'd20, 1'b1, 32'hffffffff, 1'b1);
        add_row(ex_pkg::OP_MFLO,  32'h00000000, 32'h00000000, 5'd21, 1'b1, 32'hfffffff1, 1'b1);
        add_row(ex_pkg::OP_MULTU, 32'hffffffff, 32'h00000002, 5'd22, 1'b0, 32'hfffffffe, 1'b0);
        add_row(ex_pkg::OP_MFHI,  32'h00000000, 32'h00000000, 5'd23, 1'b1, 32'h00000001, 1'b1);
        // Moves to and from HI/LO back to back
        add_row(ex_pkg::OP_MTHI,  32'hdeadbeef, 32'h00000000, 5'd24, 1'b0, 32'h00000000, 1'b0);
        add_row(ex_pkg::OP_MTLO,  32'h13579bdf, 32'h00000000, 5'd25, 1'b0, 32'h00000000, 1'b0);
        add_row(ex_pkg::OP_MFHI,  32'h00000000, 32'h00000000, 5'd26, 1'b1, 32'hdeadbeef, 1'b1);
        add_row(ex_pkg::OP_MFLO,  32'h00000000, 32'h00000000, 5'd27, 1'b1, 32'h13579bdf, 1'b1);
        add_row(ex_pkg::OP_MTHI,  32'h2468ace0, 32'h00000000, 5'd28, 1'b0, 32'h00000000, 1'b0);
        add_row(ex_pkg::OP_MFLO,  32'h00000000, 32'h00000000, 5'd29, 1'b1, 32'h13579bdf, 1'b1);
        add_row(ex_pkg::OP_MFHI,  32'h00000000, 32'h00000000, 5'd30, 1'b1, 32'h2468ace0, 1'b1);
        add_row(ex_pkg::OP_ADDU,  32'h00000001, 32'h00000002, 5'd31, 1'b0, 32'h00000003, 1'b0);
    endtask

    task automatic build_random_rows();
        int                pick;
        ex_pkg::alu_op_t   op;
        ex_pkg::word_t     a;
        ex_pkg::word_t     b;
        ex_pkg::reg_addr_t addr;
        logic              wr;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            pick = int'($unsigned($random(seed)) % 5);
            case (pick)
                0:       op = ex_pkg::OP_OR;
                1:       op = ex_pkg::OP_AND;
                2:       op = ex_pkg::OP_NOR;
                3:       op = ex_pkg::OP_XOR;
                default: op = ex_pkg::OP_ADDU;
            endcase
            a    = $random(seed);
            b    = $random(seed);
            addr = 5'($random(seed));
            wr   = 1'($random(seed));
            add_row(op, a, b, addr, wr, reference_result(op, a, b), wr);
        end
    endtask

    task automatic drive_row(input int i);
        in_valid   <= row_valid[i];
        operator   <= row_op[i];
        operand1   <= row_operand1[i];
        operand2   <= row_operand2[i];
        dest_addr  <= row_addr[i];
        dest_write <= row_write[i];
    endtask

    task automatic check_row(input int i);
        check_value("out_valid", 32'(out_valid), 32'(row_valid[i]));
        check_value("write_enable", 32'(write_enable), 32'(row_exp_enable[i]));
        check_value("write_addr", 32'(write_addr), 32'(row_addr[i]));
        if (row_valid[i]) begin
            check_value("write_data", write_data, row_exp_data[i]);
        end
    endtask

    initial begin
        reset      = 1'b1;
        in_valid   = 1'b0;
        operator   = ex_pkg::OP_NOP;
        operand1   = '0;
        operand2   = '0;
        dest_addr  = '0;
        dest_write = 1'b0;
        build_fixed_rows();
        build_random_rows();
        table_ready = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("write_enable", 32'(write_enable), 32'd0);
        check_value("write_data", write_data, 32'd0);
        check_value("write_addr", 32'(write_addr), 32'd0);

        @(posedge clk);  // First edge out of reset sees in_valid low
        @(negedge clk);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("write_enable", 32'(write_enable), 32'd0);

        for (int i = 0; i < row_count; i++) begin
            @(posedge clk);
            drive_row(i);
            @(negedge clk);
            if (i > 0) begin
                check_row(i - 1);  // Result of the row issued one edge earlier
            end
        end
        @(posedge clk);
        in_valid   <= 1'b0;
        dest_write <= 1'b0;
        @(negedge clk);
        check_row(row_count - 1);

        $display("Rows: %0d, checks: %0d, errors: %0d", row_count, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #((row_count + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("Timeout: the run did not finish in the expected number of cycles");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- list.f
ex_pkg.sv
ex_op_if.sv
ex_logic_shift.sv
ex_arith.sv
ex_mult.sv
ex_hilo.sv
ex_result_stage.sv
ex_top.sv
tb_ex_top.sv

//--- Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ex_top
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

test: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "\*\*\* TEST PASSED \*\*\*" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
